/* vc_link_defines.svh */
// VC link configuration
// Sizes shared by the port buffers, credit counters and arbiter

`ifndef VC_LINK_DEFINES_SVH
`define VC_LINK_DEFINES_SVH

// Virtual channels sharing one physical link
`define VC_LINK_NUM_VC 2

// Flit payload width in bits
`define VC_LINK_PAYLOAD_W 32

// Credits per VC after reset, equal to the downstream buffer depth
`define VC_LINK_NUM_CREDITS 3

// Entries in each per-VC input buffer
`define VC_LINK_FIFO_DEPTH 2

`endif

/* vc_link_pkg.sv */
// VC link types
// Flit layout and VC index shared by every block of the output port

`default_nettype none

`include "vc_link_defines.svh"

package vc_link_pkg;

  // Index of one virtual channel
  typedef logic [$clog2(`VC_LINK_NUM_VC)-1:0] vc_idx_t;

  // Flit on the link
  // payload is carried untouched, src_vc records the entry VC
  typedef struct packed {
    logic [`VC_LINK_PAYLOAD_W-1:0] payload;
    vc_idx_t                       src_vc;
  } flit_t;

endpackage

`default_nettype wire

/* vc_chan_if.sv */
// One virtual channel between a flit buffer and the VC arbiter
// Valid/ready handshake for flits plus a one-cycle credit pulse

`timescale 1ns/1ps
`default_nettype none

interface vc_chan_if;

  // Flit offered by the sender, held stable until ready
  logic                valid;
  vc_link_pkg::flit_t  flit;

  // Acceptance from the receiver
  logic                ready;

  // One buffer slot returned, single-cycle pulse
  logic                credit;

  // Buffer side
  modport sender (
    output valid,
    output flit,
    input  ready,
    input  credit
  );

  // Arbiter side
  modport receiver (
    input  valid,
    input  flit,
    output ready,
    output credit
  );

endinterface

`default_nettype wire

/* vc_flit_fifo.sv */
// Per-VC input flit buffer
// Two-entry circular FIFO with valid/ready on both sides that stamps the source VC

`timescale 1ns/1ps
`default_nettype none

`include "vc_link_defines.svh"

module vc_flit_fifo #(
  parameter vc_link_pkg::vc_idx_t VC_ID = '0
) (
  input  wire logic               clk_i,
  input  wire logic               reset_i,
  // Upstream side
  input  wire logic               in_valid_i,
  input  wire vc_link_pkg::flit_t in_data_i,
  output logic                    in_ready_o,
  // Toward the VC arbiter
  vc_chan_if.sender               out_chan
);

  localparam int unsigned DEPTH = `VC_LINK_FIFO_DEPTH;

  typedef logic [$clog2(DEPTH)-1:0]   ptr_t;
  typedef logic [$clog2(DEPTH+1)-1:0] cnt_t;

  // Entry storage
  vc_link_pkg::flit_t mem_q [DEPTH];

  ptr_t wr_ptr_q;
  ptr_t rd_ptr_q;
  cnt_t cnt_q;

  logic push;
  logic pop;

  // Room while fewer than DEPTH entries are held
  assign in_ready_o = (cnt_q < cnt_t'(DEPTH));
  assign push       = in_valid_i & in_ready_o;

  // Head of queue straight from storage so a push never passes through in the same cycle
  assign out_chan.valid = (cnt_q != '0);
  assign out_chan.flit  = mem_q[rd_ptr_q];
  assign pop            = out_chan.valid & out_chan.ready;

  // Write side tags the flit with this buffer's VC
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q].payload <= in_data_i.payload;
      mem_q[wr_ptr_q].src_vc  <= VC_ID;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
      if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
      // Simultaneous push and pop keeps the count
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* credit_counter.sv */
// Downstream credit counter for one VC
// Tracks free slots at the next router, flags whether one is left

`timescale 1ns/1ps
`default_nettype none

`include "vc_link_defines.svh"

module credit_counter (
  input  wire logic clk_i,
  input  wire logic reset_i,
  // Slot freed downstream
  input  wire logic credit_give_i,
  // Flit sent on the link
  input  wire logic credit_take_i,
  output logic      credit_left_o
);

  localparam int unsigned NUM_CREDITS = `VC_LINK_NUM_CREDITS;

  typedef logic [$clog2(NUM_CREDITS+1)-1:0] cnt_t;

  cnt_t cnt_q;

  // Up/down count, saturates at both ends
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Downstream buffer starts empty
      cnt_q <= cnt_t'(NUM_CREDITS);
    end else begin
      case ({credit_give_i, credit_take_i})
        2'b10: begin
          if (cnt_q != cnt_t'(NUM_CREDITS)) cnt_q <= cnt_q + 1'b1;
        end
        2'b01: begin
          if (cnt_q != '0) cnt_q <= cnt_q - 1'b1;
        end
        // Give and take on one edge cancel
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Registered count only
  assign credit_left_o = (cnt_q != '0);

endmodule

`default_nettype wire

/* rr_vc_arbiter.sv */
// Round-robin VC arbiter with flit mux
// Combinational pick from the pointer that moves on a granted transfer

`timescale 1ns/1ps
`default_nettype none

`include "vc_link_defines.svh"

module rr_vc_arbiter (
  input  wire logic                                     clk_i,
  input  wire logic                                     reset_i,
  // Requests and flits from the VCs
  input  wire logic [`VC_LINK_NUM_VC-1:0]               req_i,
  input  wire vc_link_pkg::flit_t [`VC_LINK_NUM_VC-1:0] data_i,
  output logic [`VC_LINK_NUM_VC-1:0]                    gnt_o,
  // Toward the link
  output logic                                          req_o,
  input  wire logic                                     gnt_i,
  output vc_link_pkg::flit_t                            data_o,
  output vc_link_pkg::vc_idx_t                          idx_o
);

  localparam int unsigned NUM_VC = `VC_LINK_NUM_VC;

  // First VC to look at this cycle
  vc_link_pkg::vc_idx_t rr_q;

  // Winner held while the link stalls
  logic                 lock_q;
  vc_link_pkg::vc_idx_t lock_idx_q;

  ////////////////////////////////////////////////////////////////////////////
  // Winner selection
  ////////////////////////////////////////////////////////////////////////////

  // Scan from the far end back to the pointer
  // so the nearest requester at or after rr_q wins
  always_comb begin
    int unsigned cand;
    idx_o = rr_q;
    for (int i = NUM_VC - 1; i >= 0; i--) begin
      cand = (int'(rr_q) + i) % NUM_VC;
      if (req_i[cand]) begin
        idx_o = vc_link_pkg::vc_idx_t'(cand);
      end
    end
    // A stalled winner keeps the link until its handshake
    if (lock_q) begin
      idx_o = lock_idx_q;
    end
  end

  assign req_o  = |req_i;
  assign data_o = data_i[idx_o];

  // One-hot grant on the winner gated by the link's acceptance
  always_comb begin
    gnt_o        = '0;
    gnt_o[idx_o] = req_o & gnt_i;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pointer update
  ////////////////////////////////////////////////////////////////////////////

  // Holds under back-pressure so the offered flit stays put
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_q <= '0;
    end else if (req_o && gnt_i) begin
      // Step past the winner
      rr_q <= vc_link_pkg::vc_idx_t'((int'(idx_o) + 1) % NUM_VC);
    end
  end

  // Offered but not accepted, so the same VC stays on the link
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      lock_q     <= req_o & ~gnt_i;
      lock_idx_q <= idx_o;
    end
  end

endmodule

`default_nettype wire

/* floo_vc_arbiter.sv */
// Credit-gated VC arbiter for one physical link
// VCs compete only while they hold a downstream credit, one wins per cycle

`timescale 1ns/1ps
`default_nettype none

`include "vc_link_defines.svh"

module floo_vc_arbiter (
  input  wire logic                         clk_i,
  input  wire logic                         reset_i,
  // Per-VC buffers
  vc_chan_if.receiver                       vc_chan [`VC_LINK_NUM_VC],
  // Physical link toward the downstream router
  input  wire logic [`VC_LINK_NUM_VC-1:0]   link_ready_i,
  output logic [`VC_LINK_NUM_VC-1:0]        link_valid_o,
  output vc_link_pkg::flit_t                link_data_o,
  // Returned slots, one pulse per freed entry
  input  wire logic [`VC_LINK_NUM_VC-1:0]   credit_i
);

  // Buffer side, unpacked from the interfaces
  logic [`VC_LINK_NUM_VC-1:0]               chan_valid;
  vc_link_pkg::flit_t [`VC_LINK_NUM_VC-1:0] chan_flit;
  logic [`VC_LINK_NUM_VC-1:0]               chan_gnt;

  // Credit state per VC
  logic [`VC_LINK_NUM_VC-1:0]               credit_left;
  logic [`VC_LINK_NUM_VC-1:0]               credit_take;

  // Arbiter hookup
  logic [`VC_LINK_NUM_VC-1:0]               arb_req;
  logic                                     arb_req_out;
  logic                                     arb_gnt_in;
  vc_link_pkg::vc_idx_t                     arb_idx;

  ////////////////////////////////////////////////////////////////////////////
  // Per-VC channel and credit logic
  ////////////////////////////////////////////////////////////////////////////

  for (genvar v = 0; v < `VC_LINK_NUM_VC; v++) begin : gen_vc
    assign chan_valid[v] = vc_chan[v].valid;
    assign chan_flit[v]  = vc_chan[v].flit;

    // Buffer pops exactly on its link handshake
    assign vc_chan[v].ready = chan_gnt[v];

    // Downstream returns mirrored on the channel
    assign vc_chan[v].credit = credit_i[v];

    credit_counter i_vc_credit_counter (
      .clk_i         ( clk_i          ),
      .reset_i       ( reset_i        ),
      .credit_give_i ( credit_i[v]    ),
      .credit_take_i ( credit_take[v] ),
      .credit_left_o ( credit_left[v] )
    );
  end

  // No request without a slot downstream
  // keeps requests steady while the winner waits on ready
  assign arb_req = chan_valid & credit_left;

  // Credit spent on each accepted flit
  assign credit_take = link_valid_o & link_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // Arbitration onto the link
  ////////////////////////////////////////////////////////////////////////////

  // Only the winning VC's ready matters for the grant
  assign arb_gnt_in = link_ready_i[arb_idx];

  rr_vc_arbiter i_rr_vc_arbiter (
    .clk_i   ( clk_i       ),
    .reset_i ( reset_i     ),
    .req_i   ( arb_req     ),
    .data_i  ( chan_flit   ),
    .gnt_o   ( chan_gnt    ),
    .req_o   ( arb_req_out ),
    .gnt_i   ( arb_gnt_in  ),
    .data_o  ( link_data_o ),
    .idx_o   ( arb_idx     )
  );

  // Winner index to one-hot link valid
  always_comb begin
    link_valid_o          = '0;
    link_valid_o[arb_idx] = arb_req_out;
  end

endmodule

`default_nettype wire

/* vc_link_top.sv */
// Router output port with two virtual channels on one link
// Per-VC input buffers feeding the credit-gated VC arbiter

`timescale 1ns/1ps
`default_nettype none

`include "vc_link_defines.svh"

module vc_link_top (
  input  wire logic                                            clk_i,
  input  wire logic                                            reset_i,
  // Upstream, one lane per VC
  input  wire logic [`VC_LINK_NUM_VC-1:0]                      vc_valid_i,
  output logic [`VC_LINK_NUM_VC-1:0]                           vc_ready_o,
  input  wire logic [`VC_LINK_NUM_VC-1:0][`VC_LINK_PAYLOAD_W-1:0] vc_data_i,
  // Downstream link, valid one-hot across VCs
  output logic [`VC_LINK_NUM_VC-1:0]                           link_valid_o,
  input  wire logic [`VC_LINK_NUM_VC-1:0]                      link_ready_i,
  output vc_link_pkg::flit_t                                   link_data_o,
  input  wire logic [`VC_LINK_NUM_VC-1:0]                      credit_i
);

  // Buffer to arbiter channels
  vc_chan_if vc_chan [`VC_LINK_NUM_VC] ();

  // Payloads wrapped as flits for the buffers
  vc_link_pkg::flit_t [`VC_LINK_NUM_VC-1:0] in_flit;

  ////////////////////////////////////////////////////////////////////////////
  // Input buffers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar v = 0; v < `VC_LINK_NUM_VC; v++) begin : gen_buf
    // Tag filled in by the buffer itself
    assign in_flit[v].payload = vc_data_i[v];
    assign in_flit[v].src_vc  = '0;

    vc_flit_fifo #(
      .VC_ID ( vc_link_pkg::vc_idx_t'(v) )
    ) i_vc_flit_fifo (
      .clk_i      ( clk_i         ),
      .reset_i    ( reset_i       ),
      .in_valid_i ( vc_valid_i[v] ),
      .in_data_i  ( in_flit[v]    ),
      .in_ready_o ( vc_ready_o[v] ),
      .out_chan   ( vc_chan[v]    )
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Link arbitration
  ////////////////////////////////////////////////////////////////////////////

  floo_vc_arbiter i_floo_vc_arbiter (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .vc_chan      ( vc_chan      ),
    .link_ready_i ( link_ready_i ),
    .link_valid_o ( link_valid_o ),
    .link_data_o  ( link_data_o  ),
    .credit_i     ( credit_i     )
  );

endmodule

`default_nettype wire

/* vc_link_properties.sv */
// Protocol checks for the two-VC router output port
// Bound into the top level where every failure raises $error

`timescale 1ns/1ps
`default_nettype none

`include "vc_link_defines.svh"

module vc_link_properties (
  input wire logic                       clk_i,
  input wire logic                       reset_i,
  input wire logic [`VC_LINK_NUM_VC-1:0] vc_valid_i,
  input wire logic [`VC_LINK_NUM_VC-1:0] vc_ready_o,
  input wire logic [`VC_LINK_NUM_VC-1:0] link_valid_o,
  input wire logic [`VC_LINK_NUM_VC-1:0] link_ready_i,
  input wire vc_link_pkg::flit_t         link_data_o,
  input wire logic [`VC_LINK_NUM_VC-1:0] credit_i
);

  localparam int NUM_CREDITS = `VC_LINK_NUM_CREDITS;

  // Count of failed assertions
  int fail_cnt = 0;

  // Flits in flight downstream and flits held in each input buffer
  int                         out_cnt [`VC_LINK_NUM_VC];
  int                         buf_cnt [`VC_LINK_NUM_VC];
  vc_link_pkg::vc_idx_t       last_vc_q;
  logic [`VC_LINK_NUM_VC-1:0] link_hs;
  logic [`VC_LINK_NUM_VC-1:0] pending;
  // Link offered a flit last cycle that was not taken
  logic                       stall_q;

  assign link_hs = link_valid_o & link_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      // Pointer starts at VC 0 as if the last VC had just sent
      last_vc_q <= vc_link_pkg::vc_idx_t'(`VC_LINK_NUM_VC - 1);
      stall_q   <= 1'b0;
      for (int v = 0; v < `VC_LINK_NUM_VC; v++) begin
        out_cnt[v] <= 0;
        buf_cnt[v] <= 0;
      end
    end else begin
      stall_q <= |(link_valid_o & ~link_ready_i);
      for (int v = 0; v < `VC_LINK_NUM_VC; v++) begin
        out_cnt[v] <= out_cnt[v] + int'(link_hs[v]) - int'(credit_i[v]);
        buf_cnt[v] <= buf_cnt[v] + int'(vc_valid_i[v] & vc_ready_o[v]) - int'(link_hs[v]);
        if (link_hs[v]) last_vc_q <= vc_link_pkg::vc_idx_t'(v);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-VC checks
  ////////////////////////////////////////////////////////////////////////////

  for (genvar v = 0; v < `VC_LINK_NUM_VC; v++) begin : gen_vc
    // A VC holding a flit and a credit is requesting
    assign pending[v] = (buf_cnt[v] != 0) && (out_cnt[v] < NUM_CREDITS);

    // VC stays off the link once all credits are spent
    a_credit_limit: assert property (@(posedge clk_i) disable iff (reset_i)
      (out_cnt[v] >= NUM_CREDITS) |-> !link_valid_o[v])
      else begin
        $error("VC %0d sent with no downstream credit left", v);
        fail_cnt++;
      end

    // Offered flit held while the link stalls
    a_stall_hold: assert property (@(posedge clk_i) disable iff (reset_i)
      (link_valid_o[v] && !link_ready_i[v]) |=> ($stable(link_valid_o) && $stable(link_data_o)))
      else begin
        $error("link changed under back-pressure on VC %0d", v);
        fail_cnt++;
      end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Link-wide checks
  ////////////////////////////////////////////////////////////////////////////

  a_link_onehot: assert property (@(posedge clk_i) disable iff (reset_i)
    $onehot0(link_valid_o))
    else begin
      $error("more than one VC valid on the link");
      fail_cnt++;
    end

  // With both VCs ready and no stall held over, the one that sent last waits
  a_rr_fair: assert property (@(posedge clk_i) disable iff (reset_i)
    (&pending && &link_ready_i && !stall_q) |-> !link_valid_o[last_vc_q])
    else begin
      $error("VC %0d won twice while the other VC was waiting", last_vc_q);
      fail_cnt++;
    end

  a_reset_state: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (link_valid_o == '0 && &vc_ready_o))
    else begin
      $error("port not idle in the first cycle after reset");
      fail_cnt++;
    end

endmodule

`default_nettype wire

/* vc_link_tb.sv */
// Testbench for the two-VC router output port
// Random upstream traffic, downstream credit model, per-VC scoreboard

`timescale 1ns/1ps
`default_nettype none

`include "vc_link_defines.svh"

module vc_link_tb;

  localparam int NUM_VC      = `VC_LINK_NUM_VC;
  localparam int NUM_CREDITS = `VC_LINK_NUM_CREDITS;

  logic                                      clk;
  logic                                      reset;
  logic [NUM_VC-1:0]                         vc_valid;
  logic [NUM_VC-1:0]                         vc_ready;
  logic [NUM_VC-1:0][`VC_LINK_PAYLOAD_W-1:0] vc_data;
  logic [NUM_VC-1:0]                         link_valid;
  logic [NUM_VC-1:0]                         link_ready;
  vc_link_pkg::flit_t                        link_data;
  logic [NUM_VC-1:0]                         credit;

  // Traffic knobs set by the main sequence
  int    seed;
  int    valid_pct;
  int    ready_pct;
  int    drain_pct;
  bit    hold_credits;
  int    quota [NUM_VC];
  string test_name;

  // Sent, received and downstream-held flits per VC
  int                            sent [NUM_VC];
  int                            rcv_cnt [NUM_VC];
  int                            ds_cnt [NUM_VC];
  int                            base [NUM_VC];
  int                            err_cnt;
  bit [NUM_VC-1:0]               push_q;
  bit [NUM_VC-1:0]               hs_q;
  logic [`VC_LINK_PAYLOAD_W-1:0] exp_q [NUM_VC][$];

  vc_link_top uut (
    .clk_i        ( clk        ),
    .reset_i      ( reset      ),
    .vc_valid_i   ( vc_valid   ),
    .vc_ready_o   ( vc_ready   ),
    .vc_data_i    ( vc_data    ),
    .link_valid_o ( link_valid ),
    .link_ready_i ( link_ready ),
    .link_data_o  ( link_data  ),
    .credit_i     ( credit     )
  );

  bind vc_link_top vc_link_properties i_vc_link_properties (
    .clk_i        ( clk_i        ),
    .reset_i      ( reset_i      ),
    .vc_valid_i   ( vc_valid_i   ),
    .vc_ready_o   ( vc_ready_o   ),
    .link_valid_o ( link_valid_o ),
    .link_ready_i ( link_ready_i ),
    .link_data_o  ( link_data_o  ),
    .credit_i     ( credit_i     )
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic bit roll(input int pct);
    roll = (($random(seed) & 32'h7fff_ffff) % 100) < pct;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Scoreboard sampled on the falling edge where outputs are settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin : monitor
    vc_link_pkg::flit_t exp_flit;
    for (int v = 0; v < NUM_VC; v++) begin
      push_q[v] = !reset && vc_valid[v] && vc_ready[v];
      hs_q[v]   = !reset && link_valid[v] && link_ready[v];
      // A flit accepted on this edge cannot leave on the same edge
      if (hs_q[v]) begin
        rcv_cnt[v]++;
        if (exp_q[v].size() == 0) begin
          $display("%s: flit left on VC %0d with none expected", test_name, v);
          err_cnt++;
        end else begin
          // Payload untouched and tagged with the VC it entered on
          exp_flit.payload = exp_q[v].pop_front();
          exp_flit.src_vc  = vc_link_pkg::vc_idx_t'(v);
          if (link_data !== exp_flit) begin
            $display("MISMATCH %s vc%0d expected %h actual %h",
                     test_name, v, exp_flit, link_data);
            err_cnt++;
          end
        end
      end
      if (push_q[v]) exp_q[v].push_back(vc_data[v]);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Upstream senders and downstream router driven 1 ns after each rising edge
  ////////////////////////////////////////////////////////////////////////////

  always begin : driver
    @(posedge clk);
    #1;
    for (int v = 0; v < NUM_VC; v++) begin
      if (push_q[v]) begin
        vc_valid[v] = 1'b0;
        sent[v]++;
      end
      if (!vc_valid[v] && sent[v] < quota[v] && roll(valid_pct)) begin
        vc_valid[v] = 1'b1;
        vc_data[v]  = $random(seed);
      end
      // Three-slot model buffer fills on handshakes and drains into credits
      ds_cnt[v] += int'(hs_q[v]);
      credit[v] = 1'b0;
      if (!hold_credits && ds_cnt[v] > 0 && roll(drain_pct)) begin
        credit[v] = 1'b1;
        ds_cnt[v]--;
      end
      link_ready[v] = roll(ready_pct);
    end
  end

  // A need of 0 waits for a full drain and any other need for that many flits per VC
  task automatic wait_phase(input int need, input int limit);
    int cycles;
    bit done;
    cycles = 0;
    done   = 1'b0;
    while (!done && cycles < limit) begin
      @(posedge clk);
      cycles++;
      done = 1'b1;
      for (int v = 0; v < NUM_VC; v++) begin
        if (need > 0) begin
          if (rcv_cnt[v] - base[v] < need) done = 1'b0;
        end else if (sent[v] != quota[v] || vc_valid[v] || exp_q[v].size() != 0
                     || hs_q[v] || ds_cnt[v] != 0) begin
          done = 1'b0;
        end
      end
    end
    if (!done) begin
      $display("%s stalled: link traffic not done after %0d cycles", test_name, limit);
      err_cnt++;
    end
  endtask

  initial begin : main
    seed       = 69;
    reset      = 1'b1;
    vc_valid   = '0;
    vc_data    = '0;
    link_ready = '0;
    credit     = '0;
    test_name  = "reset";
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    @(posedge clk);

    // Random traffic with link back-pressure
    test_name = "random_traffic";
    valid_pct = 60;
    ready_pct = 50;
    drain_pct = 40;
    for (int v = 0; v < NUM_VC; v++) quota[v] += 24;
    wait_phase(0, 600);

    // Each VC stalls once its credits are spent while returns are withheld
    test_name    = "credit_limit";
    hold_credits = 1'b1;
    valid_pct    = 100;
    ready_pct    = 100;
    for (int v = 0; v < NUM_VC; v++) begin
      base[v] = rcv_cnt[v];
      quota[v] += 5;
    end
    wait_phase(NUM_CREDITS, 100);
    repeat (12) @(posedge clk);
    for (int v = 0; v < NUM_VC; v++) begin
      if (rcv_cnt[v] - base[v] != NUM_CREDITS) begin
        $display("MISMATCH %s vc%0d expected %0d actual %0d",
                 test_name, v, NUM_CREDITS, rcv_cnt[v] - base[v]);
        err_cnt++;
      end
    end
    hold_credits = 1'b0;
    drain_pct    = 50;
    wait_phase(0, 200);

    // Both VCs loaded back to back so grants alternate
    test_name = "fairness";
    drain_pct = 100;
    for (int v = 0; v < NUM_VC; v++) quota[v] += 16;
    wait_phase(0, 300);

    $display("closing: %0d scoreboard errors, %0d assertion failures",
             err_cnt, uut.i_vc_link_properties.fail_cnt);
    if (err_cnt == 0 && uut.i_vc_link_properties.fail_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
vc_link_pkg.sv
vc_chan_if.sv
vc_flit_fifo.sv
credit_counter.sv
rr_vc_arbiter.sv
floo_vc_arbiter.sv
vc_link_top.sv
vc_link_properties.sv
vc_link_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the VC link testbench with Verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module vc_link_tb \
  -f filelist.f -o vc_link_sim &&
./obj_dir/vc_link_sim +verilator+error+limit+1000 | tee /dev/stderr \
  | grep -F '*** PASSED ***' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
